//--- tb.f
source/flow_pkg.sv
source/flow_ctrl_fsm.sv
source/urom_addr_counter.sv
source/irq_urom.sv
source/inst_select.sv
source/flow_ctrl_top.sv
tb/tb_flow_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the flow control testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_flow_ctrl
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module "$TOP" -Mdir "$OBJ"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$("./$OBJ/V$TOP")
status=$?
echo "$out"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# pass only when the testbench printed its pass line
if echo "$out" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi

echo "pass line not found in the simulation output"
exit 1

//--- tb/tb_flow_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module tb_flow_ctrl import flow_pkg::*; ();

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 10;
   localparam int SEED         = 93812;
   // upper bound on the directed phases with their random waits
   localparam int DIRECTED_MAX = 100;
   localparam int N_RAND       = 400;
   localparam int TEST_CYCLES  = RESET_CYCLES + DIRECTED_MAX + N_RAND;

   logic clk = 1'b0;
   logic rst_n;

   // dut inputs
   cpu_events_t       events;
   logic              data_ready;
   logic              code_ready;
   logic              irq;
   logic [INST_W-1:0] fetch_inst;

   // dut outputs
   flow_cmd_t         flow;
   logic              irq_ack;
   logic              in_handler;
   pstate_e           pstate;
   logic [INST_W-1:0] inst;
   logic              inst_valid;

   int mismatch_count = 0;
   int other_count    = 0;
   int ack_count      = 0;

   // reference model state
   pstate_e           m_state      = RESET;
   logic              m_rst_done   = 1'b0;
   logic              m_in_handler = 1'b0;
   int                m_seq_pos    = 0;
   logic              m_valid      = 1'b0;
   logic [INST_W-1:0] m_inst       = '0;

   flow_ctrl_top u_flow_ctrl_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .events     (events),
      .data_ready (data_ready),
      .code_ready (code_ready),
      .irq        (irq),
      .fetch_inst (fetch_inst),
      .flow       (flow),
      .irq_ack    (irq_ack),
      .in_handler (in_handler),
      .pstate     (pstate),
      .inst       (inst),
      .inst_valid (inst_valid)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // expected rom word is addi x0 with immediate addr + 16 inside a sequence
   function automatic logic [INST_W-1:0] expected_rom_word(input logic [UROM_ADDR_W-1:0] addr);
      int          a;
      logic [11:0] imm;
      a   = int'(addr);
      imm = 12'd0;
      if ((a >= int'(ENTRY_START) && a < int'(ENTRY_START) + ENTRY_LEN) ||
          (a >= int'(EXIT_START) && a < int'(EXIT_START) + EXIT_LEN)) begin
         imm = 12'(a + 16);
      end
      // imm, rs1, funct3, rd, opcode
      return {imm, 5'd0, 3'd0, 5'd0, UROM_OPCODE};
   endfunction

   // advance one cycle and land new inputs 10 ns after the edge
   task automatic step_cycle();
      @(posedge clk);
      #10;
      fetch_inst = $urandom();
   endtask

   task automatic wait_for_state(input pstate_e target, input int limit);
      int cycles;
      cycles = 0;
      while (pstate != target && cycles < limit) begin
         step_cycle();
         cycles++;
      end
      assert (pstate == target) else begin
         $display("state %0d not reached within %0d cycles at %0t", target, limit, $time);
         other_count++;
      end
   endtask

   // model step and compare at the falling edge where inputs are stable
   always @(negedge clk) begin
      flow_cmd_t              exp_flow;
      logic                   exp_ack;
      pstate_e                next_state;
      logic                   next_in_handler;
      int                     next_pos;
      int                     seq_start;
      int                     seq_len;
      logic [UROM_ADDR_W-1:0] rom_addr;
      exp_flow        = '0;
      exp_ack         = 1'b0;
      next_state      = m_state;
      next_in_handler = m_in_handler;
      next_pos        = m_seq_pos;
      rom_addr        = '0;
      if (irq_ack) begin
         ack_count++;
      end
      if (!rst_n) begin
         // all commands quiet while held in reset
         assert (flow === '0 && inst_valid === 1'b0 && pstate === RESET) else begin
            $display("Mismatch at %0t: outputs active during reset", $time);
            mismatch_count++;
         end
         m_state      = RESET;
         m_rst_done   = 1'b0;
         m_in_handler = 1'b0;
         m_valid      = 1'b0;
         // register still clocks in fetched code
         m_inst       = fetch_inst;
      end else begin
         case (m_state)
            RESET: begin
               exp_flow.stall = m_rst_done;
               if (m_rst_done) begin
                  next_state = CONT;
               end
            end
            CONT: begin
               if (events.branch_taken) begin
                  exp_flow.new_pc = 1'b1;
                  exp_flow.stall  = 1'b1;
                  next_state      = BRANCH;
               end else if (events.data_read || events.data_write) begin
                  exp_flow.data_access = 1'b1;
                  next_state           = WAIT_DATA;
               end else if (irq && !m_in_handler) begin
                  exp_ack         = 1'b1;
                  exp_flow.bypass = 1'b1;
                  rom_addr        = ENTRY_START;
                  next_pos        = 1;
                  next_state      = IRQ_SEQ;
               end else if (events.reti && m_in_handler) begin
                  exp_flow.bypass = 1'b1;
                  rom_addr        = EXIT_START;
                  next_pos        = 1;
                  next_state      = RETI_SEQ;
               end
            end
            BRANCH: begin
               exp_flow.new_pc = 1'b1;
               exp_flow.stall  = !code_ready;
               if (code_ready) begin
                  next_state = CONT;
               end
            end
            WAIT_DATA: begin
               exp_flow.stall = !data_ready;
               if (data_ready) begin
                  next_state = CONT;
               end
            end
            IRQ_SEQ, RETI_SEQ: begin
               exp_flow.bypass = 1'b1;
               seq_start = (m_state == IRQ_SEQ) ? int'(ENTRY_START) : int'(EXIT_START);
               seq_len   = (m_state == IRQ_SEQ) ? ENTRY_LEN : EXIT_LEN;
               rom_addr  = UROM_ADDR_W'(seq_start + m_seq_pos);
               // last word leaves the sequence and flips the handler flag
               if (m_seq_pos == seq_len - 1) begin
                  next_state      = CONT;
                  next_in_handler = (m_state == IRQ_SEQ);
               end else begin
                  next_pos = m_seq_pos + 1;
               end
            end
            default: begin
               next_state = CONT;
            end
         endcase

         assert (flow === exp_flow) else begin
            $display("Mismatch at %0t: flow %b, expected %b", $time, flow, exp_flow);
            mismatch_count++;
         end
         assert (pstate === m_state) else begin
            $display("Mismatch at %0t: pstate %0d, expected %0d", $time, pstate, m_state);
            mismatch_count++;
         end
         assert (irq_ack === exp_ack) else begin
            $display("Mismatch at %0t: irq_ack %b, expected %b", $time, irq_ack, exp_ack);
            mismatch_count++;
         end
         assert (in_handler === m_in_handler) else begin
            $display("Mismatch at %0t: in_handler %b, expected %b", $time, in_handler,
                     m_in_handler);
            mismatch_count++;
         end
         assert (inst_valid === m_valid) else begin
            $display("Mismatch at %0t: inst_valid %b, expected %b", $time, inst_valid, m_valid);
            mismatch_count++;
         end
         assert (inst === m_inst) else begin
            $display("Mismatch at %0t: inst %h, expected %h", $time, inst, m_inst);
            mismatch_count++;
         end

         // register behaviour at the coming edge
         m_valid = !exp_flow.stall;
         if (!exp_flow.stall) begin
            m_inst = exp_flow.bypass ? expected_rom_word(rom_addr) : fetch_inst;
         end
         m_state      = next_state;
         m_in_handler = next_in_handler;
         m_seq_pos    = next_pos;
         m_rst_done   = 1'b1;
      end
   end

   // stimulus
   initial begin
      int n;
      int acks_before;
      void'($urandom(SEED));
      rst_n      = 1'b0;
      events     = '0;
      data_ready = 1'b0;
      code_ready = 1'b0;
      irq        = 1'b0;
      fetch_inst = '0;
      repeat (RESET_CYCLES) step_cycle();
      rst_n = 1'b1;
      wait_for_state(CONT, 4);

      // taken branch with the fetch answering after a random delay
      events.branch_taken = 1'b1;
      step_cycle();
      events = '0;
      n = 1 + int'($urandom % 5);
      repeat (n) step_cycle();
      code_ready = 1'b1;
      wait_for_state(CONT, 3);
      code_ready = 1'b0;

      // data access as a read or a write
      if ($urandom % 2 == 0) begin
         events.data_read = 1'b1;
      end else begin
         events.data_write = 1'b1;
      end
      step_cycle();
      events = '0;
      n = 1 + int'($urandom % 5);
      repeat (n) step_cycle();
      data_ready = 1'b1;
      wait_for_state(CONT, 3);
      data_ready = 1'b0;

      // interrupt entry with irq held high through and after the sequence
      acks_before = ack_count;
      irq = 1'b1;
      step_cycle();
      wait_for_state(CONT, ENTRY_LEN + 4);
      repeat (3) step_cycle();
      irq = 1'b0;
      assert (ack_count - acks_before == 1) else begin
         $display("irq_ack pulsed %0d times for one interrupt", ack_count - acks_before);
         other_count++;
      end
      assert (in_handler == 1'b1) else begin
         $display("handler flag not set after the entry sequence at %0t", $time);
         other_count++;
      end

      // return from interrupt
      events.reti = 1'b1;
      step_cycle();
      events = '0;
      wait_for_state(CONT, EXIT_LEN + 4);
      assert (in_handler == 1'b0) else begin
         $display("handler flag still set after the exit sequence at %0t", $time);
         other_count++;
      end

      // reti outside the handler is ignored
      events.reti = 1'b1;
      step_cycle();
      events = '0;
      assert (pstate == CONT) else begin
         $display("reti outside the handler left CONT at %0t", $time);
         other_count++;
      end

      // random mix where the model checks the priority
      repeat (N_RAND) begin
         events.branch_taken = ($urandom % 8) == 0;
         events.data_read    = ($urandom % 8) == 0;
         events.data_write   = ($urandom % 10) == 0;
         events.reti         = ($urandom % 4) == 0;
         irq                 = ($urandom % 4) == 0;
         code_ready          = ($urandom % 2) == 0;
         data_ready          = ($urandom % 3) == 0;
         step_cycle();
      end
      events     = '0;
      irq        = 1'b0;
      code_ready = 1'b1;
      data_ready = 1'b1;
      repeat (4) step_cycle();

      $display("checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // watchdog at twice the planned run length
   initial begin
      #(TEST_CYCLES * CLK_PERIOD * 2);
      $display("watchdog expired before the stimulus finished at %0t", $time);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- source/flow_ctrl_top.sv
`default_nettype none
`timescale 1ns/100ps

module flow_ctrl_top import flow_pkg::*; (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  cpu_events_t            events,
   input  wire logic              data_ready,
   input  wire logic              code_ready,
   input  wire logic              irq,
   input  wire logic [INST_W-1:0] fetch_inst,
   output flow_cmd_t              flow,
   output logic                   irq_ack,
   output logic                   in_handler,
   output pstate_e                pstate,
   output logic      [INST_W-1:0] inst,
   output logic                   inst_valid
);

   // fsm to counter
   urom_cmd_t urom_cmd;

   // counter back to fsm
   logic seq_last;

   // micro-rom path
   logic [UROM_ADDR_W-1:0] urom_addr;
   logic [INST_W-1:0]      urom_word;

   flow_ctrl_fsm u_fsm (
      .clk        (clk),
      .rst_n      (rst_n),
      .events     (events),
      .data_ready (data_ready),
      .code_ready (code_ready),
      .irq        (irq),
      .seq_last   (seq_last),
      .flow       (flow),
      .urom_cmd   (urom_cmd),
      .irq_ack    (irq_ack),
      .in_handler (in_handler),
      .pstate     (pstate)
   );

   urom_addr_counter u_counter (
      .clk      (clk),
      .rst_n    (rst_n),
      .urom_cmd (urom_cmd),
      .addr     (urom_addr),
      .seq_last (seq_last)
   );

   irq_urom u_urom (
      .addr (urom_addr),
      .word (urom_word)
   );

   inst_select u_select (
      .clk        (clk),
      .rst_n      (rst_n),
      .fetch_inst (fetch_inst),
      .urom_word  (urom_word),
      .flow       (flow),
      .inst       (inst),
      .inst_valid (inst_valid)
   );

endmodule

`default_nettype wire

//--- source/inst_select.sv
`default_nettype none
`timescale 1ns/100ps

module inst_select import flow_pkg::*; (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic [INST_W-1:0] fetch_inst,
   input  wire logic [INST_W-1:0] urom_word,
   input  flow_cmd_t              flow,
   output logic      [INST_W-1:0] inst,
   output logic                   inst_valid
);

   // word offered to the register this cycle
   logic [INST_W-1:0] inst_next;

   // rom word overrides fetched code during a sequence
   assign inst_next = flow.bypass ? urom_word : fetch_inst;

   // instruction register, frozen while stalled
   always_ff @(posedge clk) begin
      if (!flow.stall) begin
         inst <= inst_next;
      end
   end

   // decode sees a fresh word only after a non-stalled cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         inst_valid <= 1'b0;
      end else begin
         inst_valid <= !flow.stall;
      end
   end

endmodule

`default_nettype wire

//--- source/irq_urom.sv
`default_nettype none
`timescale 1ns/100ps

module irq_urom import flow_pkg::*; (
   input  wire logic [UROM_ADDR_W-1:0] addr,
   output logic      [INST_W-1:0]      word
);

   // addi x0, x0, imm
   function automatic logic [INST_W-1:0] addi_x0(input logic [11:0] imm);
      // imm, rs1, funct3, rd, opcode
      return {imm, 5'd0, 3'b000, 5'd0, UROM_OPCODE};
   endfunction

   // immediate is the address plus 16
   always_comb begin
      case (addr)
         // entry sequence
         4'd0:    word = addi_x0(UROM_IMM_BASE + 12'd0);
         4'd1:    word = addi_x0(UROM_IMM_BASE + 12'd1);
         4'd2:    word = addi_x0(UROM_IMM_BASE + 12'd2);
         4'd3:    word = addi_x0(UROM_IMM_BASE + 12'd3);
         4'd4:    word = addi_x0(UROM_IMM_BASE + 12'd4);
         4'd5:    word = addi_x0(UROM_IMM_BASE + 12'd5);
         // exit sequence
         4'd8:    word = addi_x0(UROM_IMM_BASE + 12'd8);
         4'd9:    word = addi_x0(UROM_IMM_BASE + 12'd9);
         4'd10:   word = addi_x0(UROM_IMM_BASE + 12'd10);
         4'd11:   word = addi_x0(UROM_IMM_BASE + 12'd11);
         4'd12:   word = addi_x0(UROM_IMM_BASE + 12'd12);
         // unused slots, plain nop
         default: word = addi_x0(12'd0);
      endcase
   end

endmodule

`default_nettype wire

//--- source/urom_addr_counter.sv
`default_nettype none
`timescale 1ns/100ps

module urom_addr_counter import flow_pkg::*; (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  urom_cmd_t              urom_cmd,
   output logic [UROM_ADDR_W-1:0] addr,
   output logic                   seq_last
);

   logic [UROM_ADDR_W-1:0] addr_q;
   logic [UROM_ADDR_W-1:0] last_addr;

   // high once the exit sequence has been loaded
   logic exit_q;

   // look-ahead address, so the rom word lines up with the command cycle
   always_comb begin
      if (urom_cmd.load) begin
         addr = urom_cmd.start;
      end else if (urom_cmd.inc) begin
         addr = addr_q + 1'b1;
      end else begin
         addr = addr_q;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_q <= '0;
         exit_q <= 1'b0;
      end else begin
         addr_q <= addr;
         // remember which sequence is running
         if (urom_cmd.load) begin
            exit_q <= (urom_cmd.start == EXIT_START);
         end
      end
   end

   assign last_addr = exit_q ? EXIT_LAST : ENTRY_LAST;

   // end of sequence, seen on the word being fetched now
   assign seq_last = (addr == last_addr);

   // fsm stops incrementing at the last word
   a_no_overrun: assert property (
      @(posedge clk) disable iff (!rst_n)
      urom_cmd.inc |-> addr_q != last_addr
   );

endmodule

`default_nettype wire

//--- source/flow_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/100ps

module flow_ctrl_fsm import flow_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  cpu_events_t events,
   input  wire logic  data_ready,
   input  wire logic  code_ready,
   input  wire logic  irq,
   input  wire logic  seq_last,
   output flow_cmd_t  flow,
   output urom_cmd_t  urom_cmd,
   output logic       irq_ack,
   output logic       in_handler,
   output pstate_e    pstate
);

   pstate_e pstate_next;

   // set at the first edge after reset release
   logic rst_done;

   // any data request from decode
   logic data_req;

   assign data_req = events.data_read | events.data_write;

   // next state and command decode
   always_comb begin
      pstate_next = pstate;
      flow        = '0;
      urom_cmd    = '0;
      irq_ack     = 1'b0;

      case (pstate)
         RESET: begin
            // one stalled cycle once the clock has run past reset
            flow.stall = rst_done;
            if (rst_done) begin
               pstate_next = CONT;
            end
         end

         CONT: begin
            // priority: branch, data, irq, reti
            if (events.branch_taken) begin
               flow.new_pc = 1'b1;
               flow.stall  = 1'b1;
               pstate_next = BRANCH;
            end else if (data_req) begin
               flow.data_access = 1'b1;
               pstate_next      = WAIT_DATA;
            end else if (irq && !in_handler) begin
               irq_ack        = 1'b1;
               urom_cmd.load  = 1'b1;
               urom_cmd.start = ENTRY_START;
               // first rom word goes into the inst register now
               flow.bypass    = 1'b1;
               pstate_next    = IRQ_SEQ;
            end else if (events.reti && in_handler) begin
               urom_cmd.load  = 1'b1;
               urom_cmd.start = EXIT_START;
               flow.bypass    = 1'b1;
               pstate_next    = RETI_SEQ;
            end
            // reti outside a handler falls through here
         end

         BRANCH: begin
            // keep new pc out until the fetch side answers
            flow.new_pc = 1'b1;
            flow.stall  = !code_ready;
            if (code_ready) begin
               pstate_next = CONT;
            end
         end

         WAIT_DATA: begin
            flow.stall = !data_ready;
            if (data_ready) begin
               pstate_next = CONT;
            end
         end

         IRQ_SEQ, RETI_SEQ: begin
            // rom drives the instruction stream, events ignored
            flow.bypass  = 1'b1;
            urom_cmd.inc = 1'b1;
            if (seq_last) begin
               pstate_next = CONT;
            end
         end

         default: begin
            pstate_next = CONT;
         end
      endcase
   end

   // state register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pstate <= RESET;
      end else begin
         pstate <= pstate_next;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rst_done <= 1'b0;
      end else begin
         rst_done <= 1'b1;
      end
   end

   // handler flag, changes when a sequence finishes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_handler <= 1'b0;
      end else if (seq_last && pstate == IRQ_SEQ) begin
         in_handler <= 1'b1;
      end else if (seq_last && pstate == RETI_SEQ) begin
         in_handler <= 1'b0;
      end
   end

   // no new pc while a data access is pending
   a_no_new_pc_in_data: assert property (
      @(posedge clk) disable iff (!rst_n)
      pstate == WAIT_DATA |-> !flow.new_pc
   );

   // counter never sees both commands at once
   a_load_inc_exclusive: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(urom_cmd.load && urom_cmd.inc)
   );

   // an acknowledged interrupt always starts the entry sequence
   a_ack_enters_seq: assert property (
      @(posedge clk) disable iff (!rst_n)
      irq_ack |=> pstate == IRQ_SEQ
   );

endmodule

`default_nettype wire

//--- source/flow_pkg.sv
`default_nettype none

package flow_pkg;

   // instruction word width
   localparam int INST_W = 32;

   // micro-rom address width, 16 words
   localparam int UROM_ADDR_W = 4;

   // interrupt entry sequence
   localparam logic [UROM_ADDR_W-1:0] ENTRY_START = 4'd0;
   localparam int ENTRY_LEN = 6;

   // return-from-interrupt sequence
   localparam logic [UROM_ADDR_W-1:0] EXIT_START = 4'd8;
   localparam int EXIT_LEN = 5;

   // last word of each sequence
   localparam logic [UROM_ADDR_W-1:0] ENTRY_LAST =
      UROM_ADDR_W'(ENTRY_START + ENTRY_LEN - 1);
   localparam logic [UROM_ADDR_W-1:0] EXIT_LAST =
      UROM_ADDR_W'(EXIT_START + EXIT_LEN - 1);

   // OP-IMM major opcode, used by every rom word
   localparam logic [6:0] UROM_OPCODE = 7'b0010011;

   // offset added to the address to form the rom immediate
   localparam logic [11:0] UROM_IMM_BASE = 12'd16;

   // pipeline control states
   typedef enum logic [2:0] {
      RESET,
      CONT,
      BRANCH,
      WAIT_DATA,
      IRQ_SEQ,
      RETI_SEQ
   } pstate_e;

   // requests from the decode stage
   typedef struct packed {
      logic branch_taken;
      logic data_read;
      logic data_write;
      logic reti;
   } cpu_events_t;

   // commands to the pipeline
   typedef struct packed {
      logic stall;
      logic new_pc;
      logic data_access;
      logic bypass;
   } flow_cmd_t;

   // micro-rom counter commands
   typedef struct packed {
      logic                   load;
      logic                   inc;
      logic [UROM_ADDR_W-1:0] start;
   } urom_cmd_t;

endpackage

`default_nettype wire
